// ==== Bender.yml ====
package:
  name: mulCore

sources:
  - rtl/mulPkg.sv
  - rtl/apbRegs.sv
  - rtl/mulCtrl.sv
  - rtl/regBank.sv
  - rtl/aluUnit.sv
  - rtl/shiftReg.sv
  - rtl/mulCore.sv
  - target: simulation
    files:
      - tb/mulCoreTb.sv

// ==== compile.f ====
rtl/mulPkg.sv
rtl/apbRegs.sv
rtl/mulCtrl.sv
rtl/regBank.sv
rtl/aluUnit.sv
rtl/shiftReg.sv
rtl/mulCore.sv
tb/mulCoreTb.sv

// ==== rtl/aluUnit.sv ====
`timescale 1ns/100ps
//========================================
// Multiplier ALU with zero flag
//========================================
module aluUnit #(
	parameter int dataWidth
) (
	input  mulPkg::aluOpE        aluOp,
	input  logic [dataWidth-1:0] busA,
	input  logic [dataWidth-1:0] busB,
	output logic [dataWidth-1:0] aluOut,
	output logic                 zero
);
	import mulPkg::*;

	always_comb
	begin
		case (aluOp)
			opAnd:   aluOut = busA & busB; // Mask test
			opXor:   aluOut = busA ^ busB;
			opAdd:   aluOut = busA + busB; // Carry dropped
			opInc:   aluOut = busA + 1'b1;
			opPassA: aluOut = busA;
			opIdle:  aluOut = busA;
			default: aluOut = busA;
		endcase
	end

	assign zero = (aluOut == '0);
endmodule

// ==== rtl/apbRegs.sv ====
`timescale 1ns/100ps
//========================================
// APB slave of the multiplier
// Operands, start pulse, busy/done, errors
//========================================
module apbRegs #(
	parameter int dataWidth
) (
	input  logic                            SC_STATEMACHINE_CLOCK_50,
	input  logic                            SC_STATEMACHINE_Reset_InHigh,
	input  logic                            PSEL,
	input  logic                            PENABLE,
	input  logic                            PWRITE,
	input  logic [mulPkg::apbAddrWidth-1:0] PADDR,
	input  logic [dataWidth-1:0]            PWDATA,
	input  logic                            finish,
	input  logic [dataWidth-1:0]            result,
	output logic [dataWidth-1:0]            PRDATA,
	output logic                            PREADY,
	output logic                            PSLVERR,
	output logic [dataWidth-1:0]            fix0,
	output logic [dataWidth-1:0]            fix1,
	output logic                            start
);
	import mulPkg::*;

	logic                 access;   // Access phase of a transfer
	logic                 mapped;
	logic                 writable;
	logic                 acceptWr; // Write that takes effect
	logic                 busy;
	logic                 done;
	logic [dataWidth-1:0] statusWord;

	assign access   = PSEL && PENABLE;
	assign writable = (PADDR == addrOpA) || (PADDR == addrOpB) || (PADDR == addrCtrl);
	assign mapped   = writable || (PADDR == addrStatus) || (PADDR == addrResult);
	assign acceptWr = access && PWRITE && writable && !busy;

	// No wait states
	assign PREADY  = 1'b1;
	assign PSLVERR = access && (!mapped || (PWRITE && (busy || !writable)));

	always_ff @(posedge SC_STATEMACHINE_CLOCK_50 or posedge SC_STATEMACHINE_Reset_InHigh)
	begin
		if (SC_STATEMACHINE_Reset_InHigh)
		begin
			fix0  <= '0;
			fix1  <= '0;
			start <= 1'b0;
			busy  <= 1'b0;
			done  <= 1'b0;
		end
		else
		begin
			start <= 1'b0; // Single cycle pulse
			if (acceptWr && (PADDR == addrOpA))
				fix0 <= PWDATA;
			if (acceptWr && (PADDR == addrOpB))
				fix1 <= PWDATA;
			if (acceptWr && (PADDR == addrCtrl) && PWDATA[0])
			begin
				start <= 1'b1;
				busy  <= 1'b1;
				done  <= 1'b0; // Old done dropped on new run
			end
			else if (finish)
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// Read mux
	always_comb
	begin
		statusWord                = '0;
		statusWord[statusBusyBit] = busy;
		statusWord[statusDoneBit] = done;
		case (PADDR)
			addrOpA:    PRDATA = fix0;
			addrOpB:    PRDATA = fix1;
			addrStatus: PRDATA = statusWord;
			addrResult: PRDATA = result;
			default:    PRDATA = '0; // Ctrl and holes read zero
		endcase
	end

endmodule

// ==== rtl/mulCore.sv ====
`timescale 1ns/100ps
//========================================
// Shift-and-add multiplier top level
// APB slave, sequencer and datapath
//========================================
module mulCore #(
	parameter int dataWidth = mulPkg::defDataWidth
) (
	input  logic                            SC_STATEMACHINE_CLOCK_50,
	input  logic                            SC_STATEMACHINE_Reset_InHigh,
	input  logic                            PSEL,
	input  logic                            PENABLE,
	input  logic                            PWRITE,
	input  logic [mulPkg::apbAddrWidth-1:0] PADDR,
	input  logic [dataWidth-1:0]            PWDATA,
	output logic [dataWidth-1:0]            PRDATA,
	output logic                            PREADY,
	output logic                            PSLVERR
);
	import mulPkg::*;

	//========================================
	// Control and datapath nets
	//========================================
	logic                 start;
	logic                 finish;
	logic [dataWidth-1:0] fix0;      // Multiplicand
	logic [dataWidth-1:0] fix1;      // Multiplier
	busSelE               busASel;
	busSelE               busBSel;
	regWrSelE             wrSel;
	aluOpE                aluOp;
	logic                 shLoad;
	shiftOpE              shOp;
	logic [dataWidth-1:0] busA;
	logic [dataWidth-1:0] busB;
	logic [dataWidth-1:0] result;    // gen3
	logic [dataWidth-1:0] aluOut;
	logic                 zero;
	logic [dataWidth-1:0] shiftOut;

	apbRegs #(.dataWidth(dataWidth)) uApbRegs (
		.SC_STATEMACHINE_CLOCK_50     (SC_STATEMACHINE_CLOCK_50),
		.SC_STATEMACHINE_Reset_InHigh (SC_STATEMACHINE_Reset_InHigh),
		.PSEL    (PSEL),
		.PENABLE (PENABLE),
		.PWRITE  (PWRITE),
		.PADDR   (PADDR),
		.PWDATA  (PWDATA),
		.finish  (finish),
		.result  (result),
		.PRDATA  (PRDATA),
		.PREADY  (PREADY),
		.PSLVERR (PSLVERR),
		.fix0    (fix0),
		.fix1    (fix1),
		.start   (start)
	);

	mulCtrl uMulCtrl (
		.SC_STATEMACHINE_CLOCK_50     (SC_STATEMACHINE_CLOCK_50),
		.SC_STATEMACHINE_Reset_InHigh (SC_STATEMACHINE_Reset_InHigh),
		.start   (start),
		.zero    (zero),
		.busASel (busASel),
		.busBSel (busBSel),
		.wrSel   (wrSel),
		.aluOp   (aluOp),
		.shLoad  (shLoad),
		.shOp    (shOp),
		.finish  (finish)
	);

	regBank #(.dataWidth(dataWidth)) uRegBank (
		.SC_STATEMACHINE_CLOCK_50     (SC_STATEMACHINE_CLOCK_50),
		.SC_STATEMACHINE_Reset_InHigh (SC_STATEMACHINE_Reset_InHigh),
		.wrSel    (wrSel),
		.busASel  (busASel),
		.busBSel  (busBSel),
		.shiftOut (shiftOut),
		.fix0     (fix0),
		.fix1     (fix1),
		.busA     (busA),
		.busB     (busB),
		.result   (result)
	);

	aluUnit #(.dataWidth(dataWidth)) uAluUnit (
		.aluOp  (aluOp),
		.busA   (busA),
		.busB   (busB),
		.aluOut (aluOut),
		.zero   (zero)
	);

	shiftReg #(.dataWidth(dataWidth)) uShiftReg (
		.SC_STATEMACHINE_CLOCK_50     (SC_STATEMACHINE_CLOCK_50),
		.SC_STATEMACHINE_Reset_InHigh (SC_STATEMACHINE_Reset_InHigh),
		.shLoad   (shLoad),
		.shOp     (shOp),
		.aluOut   (aluOut),
		.shiftOut (shiftOut)
	);

endmodule

// ==== rtl/mulCtrl.sv ====
`timescale 1ns/100ps
//========================================
// Microcoded multiply sequencer
// Shift-and-add steps, drives all selects
//========================================
module mulCtrl (
	input  logic               SC_STATEMACHINE_CLOCK_50,
	input  logic               SC_STATEMACHINE_Reset_InHigh,
	input  logic               start,
	input  logic               zero,
	output mulPkg::busSelE     busASel,
	output mulPkg::busSelE     busBSel,
	output mulPkg::regWrSelE   wrSel,
	output mulPkg::aluOpE      aluOp,
	output logic               shLoad,
	output mulPkg::shiftOpE    shOp,
	output logic               finish
);
	import mulPkg::*;

	ctrlStateE state;
	ctrlStateE nextState;
	logic      secondPass; // Clear and move steps run twice
	logic      maskZero;   // Multiplier LSB was zero

	always_ff @(posedge SC_STATEMACHINE_CLOCK_50 or posedge SC_STATEMACHINE_Reset_InHigh)
	begin
		if (SC_STATEMACHINE_Reset_InHigh)
		begin
			state      <= stIdle;
			secondPass <= 1'b0;
			maskZero   <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if ((state == stClr2) || (state == stMov2))
				secondPass <= ~secondPass;
			if (state == stAnd0)
				maskZero <= zero; // Sampled while AND is on the ALU
		end
	end

	//========================================
	// Next state
	//========================================
	always_comb
	begin
		case (state)
			stIdle:   nextState = start ? stStart : stIdle;
			stStart:  nextState = stClr0;
			stClr0:   nextState = stClr1;
			stClr1:   nextState = stClr2;
			stClr2:   nextState = secondPass ? stInc0 : stClr0;
			stInc0:   nextState = stInc1;
			stInc1:   nextState = stInc2;
			stInc2:   nextState = stMov0;
			stMov0:   nextState = stMov1;
			stMov1:   nextState = stMov2;
			stMov2:   nextState = secondPass ? stTest : stMov0;
			stTest:   nextState = zero ? stDone : stAnd0; // Multiplier used up
			stAnd0:   nextState = stAnd1;
			stAnd1:   nextState = stAnd2;
			stAnd2:   nextState = maskZero ? stIncLp0 : stAdd0;
			stAdd0:   nextState = stAdd1;
			stAdd1:   nextState = stAdd2;
			stAdd2:   nextState = stShl0;
			stIncLp0: nextState = stIncLp1;
			stIncLp1: nextState = stIncLp2;
			stIncLp2: nextState = stShl0;
			stShl0:   nextState = stShl1;
			stShl1:   nextState = stShl2;
			stShl2:   nextState = stShl3;
			stShl3:   nextState = stShr0;
			stShr0:   nextState = stShr1;
			stShr1:   nextState = stShr2;
			stShr2:   nextState = stShr3;
			stShr3:   nextState = stTest;
			stDone:   nextState = stIdle;
			default:  nextState = stIdle;
		endcase
	end

	//========================================
	// Micro-operation decode
	//========================================
	always_comb
	begin
		busASel = busNone;
		busBSel = busNone;
		wrSel   = wrNone;
		aluOp   = opIdle;
		shLoad  = 1'b0;
		shOp    = shHold;
		finish  = 1'b0;
		case (state)
			stClr0, stClr1:
			begin
				busASel = secondPass ? busGen0 : busGen3; // x XOR x gives zero
				busBSel = secondPass ? busGen0 : busGen3;
				aluOp   = opXor;
				shLoad  = (state == stClr1);
			end
			stClr2: wrSel = secondPass ? wrGen0 : wrGen3;
			stInc0, stInc1, stIncLp0, stIncLp1:
			begin
				busASel = busGen0; // Mask back to one
				aluOp   = opInc;
				shLoad  = (state == stInc1) || (state == stIncLp1);
			end
			stInc2, stIncLp2: wrSel = wrGen0;
			stMov0, stMov1:
			begin
				busASel = secondPass ? busFix1 : busFix0;
				aluOp   = opPassA;
				shLoad  = (state == stMov1);
			end
			stMov2: wrSel = secondPass ? wrGen2 : wrGen1;
			stTest:
			begin
				busASel = busGen2; // Only zero flag matters
				aluOp   = opPassA;
			end
			stAnd0, stAnd1:
			begin
				busASel = busGen0;
				busBSel = busGen2;
				aluOp   = opAnd;
				shLoad  = (state == stAnd1);
			end
			stAnd2: wrSel = wrGen0;
			stAdd0, stAdd1:
			begin
				busASel = busGen3; // Accumulate multiplicand
				busBSel = busGen1;
				aluOp   = opAdd;
				shLoad  = (state == stAdd1);
			end
			stAdd2: wrSel = wrGen3;
			stShl0, stShl1, stShl2:
			begin
				busASel = busGen1;
				aluOp   = opPassA;
				shLoad  = (state != stShl0);
				shOp    = (state == stShl2) ? shLeft : shHold; // Load then shift
			end
			stShl3: wrSel = wrGen1;
			stShr0, stShr1, stShr2:
			begin
				busASel = busGen2;
				aluOp   = opPassA;
				shLoad  = (state != stShr0);
				shOp    = (state == stShr2) ? shRight : shHold;
			end
			stShr3: wrSel = wrGen2;
			stDone: finish = 1'b1;
			default: ;
		endcase
	end

endmodule

// ==== rtl/mulPkg.sv ====
//========================================
// Multiplier shared definitions
// Widths, control encodings, APB map
//========================================
package mulPkg;

	localparam int defDataWidth = 8; // Operand width at top level
	localparam int regSelWidth  = 3; // Register and bus select
	localparam int apbAddrWidth = 5;

	//========================================
	// Datapath control encodings
	//========================================
	typedef enum logic [regSelWidth-1:0] {
		busGen0 = 3'b000,
		busGen1 = 3'b001,
		busGen2 = 3'b010,
		busGen3 = 3'b011,
		busFix0 = 3'b100, // Operand A from APB
		busFix1 = 3'b101, // Operand B from APB
		busNone = 3'b111  // Bus driven to zero
	} busSelE;

	typedef enum logic [regSelWidth-1:0] {
		wrGen0 = 3'b000,
		wrGen1 = 3'b001,
		wrGen2 = 3'b010,
		wrGen3 = 3'b011,
		wrNone = 3'b111
	} regWrSelE;

	typedef enum logic [3:0] {
		opPassA = 4'b0000,
		opAnd   = 4'b0010,
		opXor   = 4'b0100,
		opAdd   = 4'b1000,
		opInc   = 4'b1010,
		opIdle  = 4'b1111 // Behaves as pass A
	} aluOpE;

	typedef enum logic [1:0] {
		shHold  = 2'b00, // Load from ALU when shLoad
		shLeft  = 2'b01,
		shRight = 2'b10
	} shiftOpE;

	// One value per micro-step
	typedef enum logic [4:0] {
		stIdle, stStart,
		stClr0, stClr1, stClr2,       // Used for gen3 then gen0
		stInc0, stInc1, stInc2,       // Mask init
		stMov0, stMov1, stMov2,       // Used for gen1 then gen2
		stTest,
		stAnd0, stAnd1, stAnd2,
		stAdd0, stAdd1, stAdd2,
		stIncLp0, stIncLp1, stIncLp2, // Mask restore in loop
		stShl0, stShl1, stShl2, stShl3,
		stShr0, stShr1, stShr2, stShr3,
		stDone
	} ctrlStateE;

	//========================================
	// APB register map
	//========================================
	localparam logic [apbAddrWidth-1:0] addrOpA    = 5'h00;
	localparam logic [apbAddrWidth-1:0] addrOpB    = 5'h04;
	localparam logic [apbAddrWidth-1:0] addrCtrl   = 5'h08; // Bit 0 starts a run
	localparam logic [apbAddrWidth-1:0] addrStatus = 5'h0C;
	localparam logic [apbAddrWidth-1:0] addrResult = 5'h10;

	localparam int statusBusyBit = 0;
	localparam int statusDoneBit = 1;

endpackage

// ==== rtl/regBank.sv ====
`timescale 1ns/100ps
//========================================
// General register bank and bus muxes
//========================================
module regBank #(
	parameter int dataWidth
) (
	input  logic                 SC_STATEMACHINE_CLOCK_50,
	input  logic                 SC_STATEMACHINE_Reset_InHigh,
	input  mulPkg::regWrSelE     wrSel,
	input  mulPkg::busSelE       busASel,
	input  mulPkg::busSelE       busBSel,
	input  logic [dataWidth-1:0] shiftOut,
	input  logic [dataWidth-1:0] fix0,
	input  logic [dataWidth-1:0] fix1,
	output logic [dataWidth-1:0] busA,
	output logic [dataWidth-1:0] busB,
	output logic [dataWidth-1:0] result
);
	import mulPkg::*;

	logic [dataWidth-1:0] genReg [4];
	logic [dataWidth-1:0] busSrc [8]; // Indexed by bus select code

	// Write decoder, data always from shifter
	always_ff @(posedge SC_STATEMACHINE_CLOCK_50 or posedge SC_STATEMACHINE_Reset_InHigh)
	begin
		if (SC_STATEMACHINE_Reset_InHigh)
		begin
			for (int i = 0; i < 4; i++)
				genReg[i] <= '0;
		end
		else
		begin
			case (wrSel)
				wrGen0:  genReg[0] <= shiftOut;
				wrGen1:  genReg[1] <= shiftOut;
				wrGen2:  genReg[2] <= shiftOut;
				wrGen3:  genReg[3] <= shiftOut;
				default: ; // wrNone
			endcase
		end
	end

	assign busSrc[0] = genReg[0];
	assign busSrc[1] = genReg[1];
	assign busSrc[2] = genReg[2];
	assign busSrc[3] = genReg[3];
	assign busSrc[4] = fix0;
	assign busSrc[5] = fix1;
	assign busSrc[6] = '0; // Unused code
	assign busSrc[7] = '0; // busNone

	assign busA   = busSrc[busASel];
	assign busB   = busSrc[busBSel];
	assign result = genReg[3]; // Accumulator
endmodule

// ==== rtl/shiftReg.sv ====
`timescale 1ns/100ps
//========================================
// Shift register behind the ALU
//========================================
module shiftReg #(
	parameter int dataWidth
) (
	input  logic                 SC_STATEMACHINE_CLOCK_50,
	input  logic                 SC_STATEMACHINE_Reset_InHigh,
	input  logic                 shLoad,
	input  mulPkg::shiftOpE      shOp,
	input  logic [dataWidth-1:0] aluOut,
	output logic [dataWidth-1:0] shiftOut
);
	import mulPkg::*;

	always_ff @(posedge SC_STATEMACHINE_CLOCK_50 or posedge SC_STATEMACHINE_Reset_InHigh)
	begin
		if (SC_STATEMACHINE_Reset_InHigh)
			shiftOut <= '0;
		else if (shLoad)
		begin
			case (shOp)
				shLeft:  shiftOut <= {shiftOut[dataWidth-2:0], 1'b0}; // Zero fill
				shRight: shiftOut <= {1'b0, shiftOut[dataWidth-1:1]};
				default: shiftOut <= aluOut; // Plain load
			endcase
		end
	end
endmodule

// ==== tb/mulCoreTb.sv ====
`timescale 1ns/100ps
//========================================
// Multiplier testbench
// Random APB runs checked against a model
//========================================
module mulCoreTb;
	import mulPkg::*;

	localparam int dataWidth  = 8;
	localparam int clkPeriod  = 40;              // ns
	localparam int randomRuns = 40;
	localparam int numRuns    = randomRuns + 8;  // Multiplies plus short tests
	localparam int runCycles  = 16 + 15 * 9 + 20; // Worst run plus APB traffic
	localparam int pollLimit  = 200;             // Status reads per run

	logic                    SC_STATEMACHINE_CLOCK_50;
	logic                    SC_STATEMACHINE_Reset_InHigh;
	logic                    PSEL;
	logic                    PENABLE;
	logic                    PWRITE;
	logic [apbAddrWidth-1:0] PADDR;
	logic [dataWidth-1:0]    PWDATA;
	logic [dataWidth-1:0]    PRDATA;
	logic                    PREADY;
	logic                    PSLVERR;

	int    seed = 28533;
	int    errorCount;
	int    testCount;
	int    failedTests;
	int    testErrBase; // Error count when the test began
	string testName;

	mulCore #(.dataWidth(dataWidth)) DUT (
		.SC_STATEMACHINE_CLOCK_50     (SC_STATEMACHINE_CLOCK_50),
		.SC_STATEMACHINE_Reset_InHigh (SC_STATEMACHINE_Reset_InHigh),
		.PSEL    (PSEL),
		.PENABLE (PENABLE),
		.PWRITE  (PWRITE),
		.PADDR   (PADDR),
		.PWDATA  (PWDATA),
		.PRDATA  (PRDATA),
		.PREADY  (PREADY),
		.PSLVERR (PSLVERR)
	);

	initial
	begin
		SC_STATEMACHINE_CLOCK_50 = 1'b0;
		forever #(clkPeriod / 2) SC_STATEMACHINE_CLOCK_50 = ~SC_STATEMACHINE_CLOCK_50;
	end

	// Watchdog sized from the worst case of every run
	initial
	begin
		#(longint'(numRuns) * runCycles * clkPeriod);
		$display("Watchdog expired, the run did not finish in time");
		$display("Testbench failed");
		$finish;
	end

	//========================================
	// APB transfers and checks
	//========================================
	task automatic apbWrite(input logic [apbAddrWidth-1:0] addr,
		input logic [dataWidth-1:0] data, output logic slvErr);
		@(negedge SC_STATEMACHINE_CLOCK_50); // Setup phase
		PSEL    = 1'b1;
		PENABLE = 1'b0;
		PWRITE  = 1'b1;
		PADDR   = addr;
		PWDATA  = data;
		@(negedge SC_STATEMACHINE_CLOCK_50); // Access phase
		PENABLE = 1'b1;
		#(clkPeriod / 4);
		slvErr = PSLVERR; // Sampled well clear of the edge
		checkReady(PREADY, "PREADY in write access");
		@(negedge SC_STATEMACHINE_CLOCK_50);
		PSEL    = 1'b0;
		PENABLE = 1'b0;
		PWRITE  = 1'b0;
	endtask

	task automatic apbRead(input logic [apbAddrWidth-1:0] addr,
		output logic [dataWidth-1:0] data, output logic slvErr);
		@(negedge SC_STATEMACHINE_CLOCK_50);
		PSEL    = 1'b1;
		PENABLE = 1'b0;
		PWRITE  = 1'b0;
		PADDR   = addr;
		@(negedge SC_STATEMACHINE_CLOCK_50);
		PENABLE = 1'b1;
		#(clkPeriod / 4);
		data   = PRDATA;
		slvErr = PSLVERR;
		checkReady(PREADY, "PREADY in read access");
		@(negedge SC_STATEMACHINE_CLOCK_50);
		PSEL    = 1'b0;
		PENABLE = 1'b0;
	endtask

	task automatic checkData(input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] exp, input string msg);
		if (got !== exp)
		begin
			errorCount++;
			$display("Mismatch at %0t: %s, got 0x%02h expected 0x%02h", $time, msg, got, exp);
		end
	endtask

	task automatic checkStatus(input logic [dataWidth-1:0] got, input logic expBusy,
		input logic expDone, input string msg);
		if ((got[statusBusyBit] !== expBusy) || (got[statusDoneBit] !== expDone))
		begin
			errorCount++;
			$display("Mismatch at %0t: %s, got busy %b done %b expected busy %b done %b",
				$time, msg, got[statusBusyBit], got[statusDoneBit], expBusy, expDone);
		end
	endtask

	task automatic checkSlvErr(input logic got, input logic exp, input string msg);
		if (got !== exp)
		begin
			errorCount++;
			$display("Mismatch at %0t: %s, PSLVERR %b expected %b", $time, msg, got, exp);
		end
	endtask

	// No wait states on any transfer
	task automatic checkReady(input logic got, input string msg);
		if (got !== 1'b1)
		begin
			errorCount++;
			$display("Mismatch at %0t: %s, PREADY %b expected 1", $time, msg, got);
		end
	endtask

	// Reference product wrapping at the data width
	function automatic logic [dataWidth-1:0] expectedProduct(input logic [dataWidth-1:0] a,
		input logic [dataWidth-1:0] b);
		int full;
		full = a * b;
		return full[dataWidth-1:0];
	endfunction

	//========================================
	// Run helpers and test bookkeeping
	//========================================
	task automatic startRun(input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		logic err;
		apbWrite(addrOpA, a, err);
		checkSlvErr(err, 1'b0, "operand A write while idle");
		apbWrite(addrOpB, b, err);
		checkSlvErr(err, 1'b0, "operand B write while idle");
		apbWrite(addrCtrl, 'd1, err); // Bit 0 starts
		checkSlvErr(err, 1'b0, "start while idle");
	endtask

	task automatic waitDone();
		logic [dataWidth-1:0] status;
		logic                 err;
		int                   polls;
		status = '0;
		polls  = 0;
		while (!status[statusDoneBit] && (polls < pollLimit))
		begin
			apbRead(addrStatus, status, err);
			polls++;
		end
		if (!status[statusDoneBit])
		begin
			errorCount++;
			$display("Run never reported done within %0d status reads", pollLimit);
		end
	endtask

	task automatic checkResult(input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		logic [dataWidth-1:0] res;
		logic                 err;
		waitDone();
		apbRead(addrResult, res, err);
		checkSlvErr(err, 1'b0, "result read");
		checkData(res, expectedProduct(a, b), $sformatf("product %0d x %0d", a, b));
	endtask

	// Corner run that also checks status just after start
	task automatic runCorner(input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		logic [dataWidth-1:0] status;
		logic                 err;
		startRun(a, b);
		apbRead(addrStatus, status, err);
		checkStatus(status, 1'b1, 1'b0, "status right after start");
		checkResult(a, b);
	endtask

	task automatic beginTest(input string name);
		testName    = name;
		testErrBase = errorCount;
		testCount++;
	endtask

	task automatic reportTest();
		if (errorCount == testErrBase)
			$display("Test %0d %s: ok", testCount, testName);
		else
		begin
			failedTests++;
			$display("Test %0d %s: %0d errors", testCount, testName, errorCount - testErrBase);
		end
	endtask

	//========================================
	// Test sequence
	//========================================
	initial
	begin : stimulus
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic [dataWidth-1:0] x;
		logic [dataWidth-1:0] rd;
		logic                 err;
		SC_STATEMACHINE_Reset_InHigh = 1'b1;
		PSEL        = 1'b0;
		PENABLE     = 1'b0;
		PWRITE      = 1'b0;
		PADDR       = '0;
		PWDATA      = '0;
		errorCount  = 0;
		testCount   = 0;
		failedTests = 0;
		testErrBase = 0;
		repeat (3) @(negedge SC_STATEMACHINE_CLOCK_50); // Three cycles of reset
		SC_STATEMACHINE_Reset_InHigh = 1'b0;

		beginTest("reset values");
		apbRead(addrStatus, rd, err);
		checkStatus(rd, 1'b0, 1'b0, "status after reset");
		checkData(rd, '0, "status word after reset");
		checkSlvErr(err, 1'b0, "status read while idle");
		apbRead(addrResult, rd, err);
		checkData(rd, '0, "result after reset");
		reportTest();

		beginTest("random operands");
		for (int i = 0; i < randomRuns; i++)
		begin
			a = $random(seed);
			b = $random(seed);
			startRun(a, b);
			checkResult(a, b);
		end
		reportTest();

		beginTest("corner operands");
		x    = $random(seed);
		x[0] = 1'b1; // Never zero
		runCorner('0, x);
		runCorner(x, '0);  // Zero multiplier ends at first test
		runCorner('d1, x);
		runCorner('1, '1); // 255 x 255
		reportTest();

		beginTest("accesses while busy");
		a    = $random(seed);
		b    = $random(seed);
		b[7] = 1'b1; // Long run of eight loop passes
		startRun(a, b);
		apbWrite(addrOpA, ~a, err);
		checkSlvErr(err, 1'b1, "operand A write while busy");
		apbRead(addrOpA, rd, err);
		checkSlvErr(err, 1'b0, "operand A read while busy");
		checkData(rd, a, "operand A after rejected write");
		apbWrite(addrCtrl, 'd1, err);
		checkSlvErr(err, 1'b1, "second start while busy");
		checkResult(a, b); // Original operands still used
		reportTest();

		beginTest("address decode");
		apbRead(5'h14, rd, err);
		checkSlvErr(err, 1'b1, "read of unmapped 0x14");
		apbWrite(5'h1C, 'h5A, err);
		checkSlvErr(err, 1'b1, "write to unmapped 0x1C");
		apbRead(5'h02, rd, err);
		checkSlvErr(err, 1'b1, "read of unaligned 0x02");
		apbRead(addrOpA, rd, err);
		checkSlvErr(err, 1'b0, "operand A read while idle");
		checkData(rd, a, "operand A after unmapped write");
		apbRead(addrOpB, rd, err);
		checkSlvErr(err, 1'b0, "operand B read while idle");
		checkData(rd, b, "operand B after unmapped write");
		apbRead(addrResult, rd, err);
		checkSlvErr(err, 1'b0, "result read while idle");
		reportTest();

		$display("Tests run %0d, tests failed %0d, checks failed %0d",
			testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
